// File: verilog/spy_pkg.sv
package spy_pkg;

	localparam int SPY_ADDR_W = 5;
	localparam int SPY_WORD_W = 16;
	localparam int PC_W = 14;
	localparam int OPC_DEPTH = 8;
	localparam int OPC_PTR_W = $clog2(OPC_DEPTH);

	localparam logic [SPY_WORD_W-1:0] SPY_IDLE = 16'hffff; // bus floats high when not reading

	// read addresses, contiguous from zero
	localparam logic [SPY_ADDR_W-1:0] SPY_A_IRH = 5'd0;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_IRM = 5'd1;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_IRL = 5'd2;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_OBH = 5'd3; // captured at state write
	localparam logic [SPY_ADDR_W-1:0] SPY_A_OBL = 5'd4;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_OBH_NOW = 5'd5; // live
	localparam logic [SPY_ADDR_W-1:0] SPY_A_OBL_NOW = 5'd6;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_DISK = 5'd7;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_BD = 5'd8;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_AH = 5'd9;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_AL = 5'd10;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_MH = 5'd11;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_ML = 5'd12;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_MDH = 5'd13;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_MDL = 5'd14;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_VMAH = 5'd15;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_VMAL = 5'd16;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_FLAG2 = 5'd17;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_OPC = 5'd18;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_FLAG1 = 5'd19;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_PC = 5'd20;
	localparam logic [SPY_ADDR_W-1:0] SPY_A_SCRATCH = 5'd21;

	localparam int SPY_NSEL = 22; // number of readable words

	// write only
	localparam logic [SPY_ADDR_W-1:0] SPY_A_MODE = 5'd22;

	// bits of the mode word
	localparam int MODE_RUN = 0;
	localparam int MODE_STEP = 1;
	localparam int MODE_PROMDIS = 2;

endpackage

// File: verilog/spy_decode.sv
`timescale 1ns/1ps

module spy_decode (
	input  logic clk,
	input  logic reset,
	input  logic [spy_pkg::SPY_ADDR_W-1:0] spy_addr,
	input  logic spy_rd,
	input  logic spy_wr,
	input  logic [spy_pkg::SPY_WORD_W-1:0] spy_wdata,
	output logic sel_irh, sel_irm, sel_irl,
	output logic sel_obh, sel_obl, sel_obh_now, sel_obl_now,
	output logic sel_disk, sel_bd,
	output logic sel_ah, sel_al, sel_mh, sel_ml,
	output logic sel_mdh, sel_mdl, sel_vmah, sel_vmal,
	output logic sel_flag2, sel_opc, sel_flag1, sel_pc, sel_scratch,
	output logic dbread,
	output logic opc_adv,
	output logic scratch_wr,
	output logic mode_wr,
	output logic [spy_pkg::SPY_WORD_W-1:0] wdata_q
);

	logic [spy_pkg::SPY_NSEL-1:0] sel_next;
	logic [spy_pkg::SPY_NSEL-1:0] sel_q;

	// codes are contiguous, so the address is the bit index
	always_comb begin
		sel_next = '0;
		if (spy_rd && spy_addr <= spy_pkg::SPY_A_SCRATCH)
			sel_next[spy_addr] = 1'b1; // out of range leaves all clear, reads idle
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_q <= '0;
			dbread <= 1'b0;
			scratch_wr <= 1'b0;
			mode_wr <= 1'b0;
			wdata_q <= '0;
		end else begin
			sel_q <= sel_next; // only one cycle wide, like dbread
			dbread <= spy_rd;
			scratch_wr <= spy_wr && spy_addr == spy_pkg::SPY_A_SCRATCH;
			mode_wr <= spy_wr && spy_addr == spy_pkg::SPY_A_MODE;
			if (spy_wr)
				wdata_q <= spy_wdata;
		end
	end

	assign sel_irh = sel_q[spy_pkg::SPY_A_IRH];
	assign sel_irm = sel_q[spy_pkg::SPY_A_IRM];
	assign sel_irl = sel_q[spy_pkg::SPY_A_IRL];
	assign sel_obh = sel_q[spy_pkg::SPY_A_OBH];
	assign sel_obl = sel_q[spy_pkg::SPY_A_OBL];
	assign sel_obh_now = sel_q[spy_pkg::SPY_A_OBH_NOW];
	assign sel_obl_now = sel_q[spy_pkg::SPY_A_OBL_NOW];
	assign sel_disk = sel_q[spy_pkg::SPY_A_DISK];
	assign sel_bd = sel_q[spy_pkg::SPY_A_BD];
	assign sel_ah = sel_q[spy_pkg::SPY_A_AH];
	assign sel_al = sel_q[spy_pkg::SPY_A_AL];
	assign sel_mh = sel_q[spy_pkg::SPY_A_MH];
	assign sel_ml = sel_q[spy_pkg::SPY_A_ML];
	assign sel_mdh = sel_q[spy_pkg::SPY_A_MDH];
	assign sel_mdl = sel_q[spy_pkg::SPY_A_MDL];
	assign sel_vmah = sel_q[spy_pkg::SPY_A_VMAH];
	assign sel_vmal = sel_q[spy_pkg::SPY_A_VMAL];
	assign sel_flag2 = sel_q[spy_pkg::SPY_A_FLAG2];
	assign sel_opc = sel_q[spy_pkg::SPY_A_OPC];
	assign sel_flag1 = sel_q[spy_pkg::SPY_A_FLAG1];
	assign sel_pc = sel_q[spy_pkg::SPY_A_PC];
	assign sel_scratch = sel_q[spy_pkg::SPY_A_SCRATCH];

	assign opc_adv = sel_q[spy_pkg::SPY_A_OPC]; // step history once the word has been read

endmodule

// File: verilog/spy_control.sv
`timescale 1ns/1ps

module spy_control (
	input  logic clk,
	input  logic reset,
	input  logic scratch_wr,
	input  logic mode_wr,
	input  logic [spy_pkg::SPY_WORD_W-1:0] wdata_q,
	input  logic state_write,
	input  logic stat_halt,
	output logic [spy_pkg::SPY_WORD_W-1:0] scratch,
	output logic srun,
	output logic ssdone,
	output logic stathalt,
	output logic promdisable,
	output logic cpu_run,
	output logic cpu_step
);

	logic step_pend; // step issued, waiting for its state write

	always_ff @(posedge clk) begin
		if (reset)
			scratch <= '0;
		else if (scratch_wr)
			scratch <= wdata_q;
	end

	// run and halt status; a mode write overrides a halt in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			srun <= 1'b0;
			promdisable <= 1'b0;
			stathalt <= 1'b0;
		end else if (mode_wr) begin
			srun <= wdata_q[spy_pkg::MODE_RUN];
			promdisable <= wdata_q[spy_pkg::MODE_PROMDIS];
			stathalt <= 1'b0;
		end else if (stat_halt && srun) begin
			stathalt <= 1'b1;
			srun <= 1'b0; // halt stops the machine
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			cpu_step <= 1'b0;
		else
			cpu_step <= mode_wr && wdata_q[spy_pkg::MODE_STEP]; // single cycle pulse
	end

	// single step completion
	always_ff @(posedge clk) begin
		if (reset) begin
			step_pend <= 1'b0;
			ssdone <= 1'b0;
		end else if (mode_wr) begin
			step_pend <= 1'b0;
			ssdone <= 1'b0;
		end else if (cpu_step) begin
			step_pend <= 1'b1;
		end else if (step_pend && state_write) begin
			step_pend <= 1'b0;
			ssdone <= 1'b1;
		end
	end

	assign cpu_run = srun;

endmodule

// File: verilog/opc_history.sv
`timescale 1ns/1ps

module opc_history (
	input  logic clk,
	input  logic reset,
	input  logic state_write,
	input  logic [spy_pkg::PC_W-1:0] pc,
	input  logic opc_adv,
	output logic [spy_pkg::PC_W-1:0] opc
);

	logic [spy_pkg::PC_W-1:0] ring [spy_pkg::OPC_DEPTH];
	logic [spy_pkg::OPC_PTR_W-1:0] wr_ptr; // next slot to fill
	logic [spy_pkg::OPC_PTR_W-1:0] rd_ptr;

	always_ff @(posedge clk) begin
		if (state_write)
			ring[wr_ptr] <= pc;
	end

	always_ff @(posedge clk) begin
		if (reset)
			wr_ptr <= '0;
		else if (state_write)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// a state write points the reader back at the newest entry
	always_ff @(posedge clk) begin
		if (reset)
			rd_ptr <= '0;
		else if (state_write)
			rd_ptr <= wr_ptr;
		else if (opc_adv)
			rd_ptr <= rd_ptr - 1'b1; // one older, wraps with the ring
	end

	assign opc = ring[rd_ptr];

endmodule

// File: verilog/spy_readout.sv
`timescale 1ns/1ps

module spy_readout (
	input  logic clk,
	input  logic reset,
	input  logic dbread,
	input  logic state_write,
	input  logic sel_irh, sel_irm, sel_irl,
	input  logic sel_obh, sel_obl, sel_obh_now, sel_obl_now,
	input  logic sel_disk, sel_bd,
	input  logic sel_ah, sel_al, sel_mh, sel_ml,
	input  logic sel_mdh, sel_mdl, sel_vmah, sel_vmal,
	input  logic sel_flag2, sel_opc, sel_flag1, sel_pc, sel_scratch,
	input  logic [48:0] ir,
	input  logic [31:0] ob,
	input  logic [31:0] md,
	input  logic [31:0] vma,
	input  logic [31:0] a,
	input  logic [31:0] m,
	input  logic [spy_pkg::PC_W-1:0] pc,
	input  logic [spy_pkg::PC_W-1:0] opc,
	input  logic [spy_pkg::SPY_WORD_W-1:0] scratch,
	input  logic [4:0] disk_state,
	input  logic [11:0] bd_state,
	input  logic wmap, destspc, iwrited, imod, pdlwrite, spush,
	input  logic nop, vmaok, jcond, pcs1, pcs0,
	input  logic waiting, boot, promdisable, stathalt, err, ssdone, srun,
	output logic [spy_pkg::SPY_WORD_W-1:0] spy_rdata
);

	logic [31:0] ob_last;
	logic [spy_pkg::SPY_WORD_W-1:0] flag1;
	logic [spy_pkg::SPY_WORD_W-1:0] flag2;
	logic [spy_pkg::SPY_WORD_W-1:0] spy_mux;

	// ob as it stood at the last state write
	always_ff @(posedge clk) begin
		if (reset)
			ob_last <= '0;
		else if (state_write)
			ob_last <= ob;
	end

	assign flag2 = {2'b00, wmap, destspc, iwrited, imod, pdlwrite, spush,
		2'b00, ir[48], nop, vmaok, jcond, pcs1, pcs0};

	assign flag1 = {waiting, 1'b0, boot, promdisable,
		stathalt, err, ssdone, srun, 8'h00};

	always_comb begin
		if (sel_irh)
			spy_mux = ir[47:32];
		else if (sel_irm)
			spy_mux = ir[31:16];
		else if (sel_irl)
			spy_mux = ir[15:0];
		else if (sel_obh)
			spy_mux = ob_last[31:16];
		else if (sel_obl)
			spy_mux = ob_last[15:0];
		else if (sel_obh_now)
			spy_mux = ob[31:16];
		else if (sel_obl_now)
			spy_mux = ob[15:0];
		else if (sel_disk)
			spy_mux = {11'b0, disk_state};
		else if (sel_bd)
			spy_mux = {4'b0, bd_state};
		else if (sel_ah)
			spy_mux = a[31:16];
		else if (sel_al)
			spy_mux = a[15:0];
		else if (sel_mh)
			spy_mux = m[31:16];
		else if (sel_ml)
			spy_mux = m[15:0];
		else if (sel_mdh)
			spy_mux = md[31:16];
		else if (sel_mdl)
			spy_mux = md[15:0];
		else if (sel_vmah)
			spy_mux = vma[31:16];
		else if (sel_vmal)
			spy_mux = vma[15:0];
		else if (sel_flag2)
			spy_mux = flag2;
		else if (sel_opc)
			spy_mux = {2'b00, opc};
		else if (sel_flag1)
			spy_mux = flag1;
		else if (sel_pc)
			spy_mux = {2'b00, pc};
		else if (sel_scratch)
			spy_mux = scratch;
		else
			spy_mux = spy_pkg::SPY_IDLE; // unused address
	end

	assign spy_rdata = dbread ? spy_mux : spy_pkg::SPY_IDLE;

endmodule

// File: verilog/spy_port.sv
`timescale 1ns/1ps

module spy_port (
	input  logic clk,
	input  logic reset,
	// debug host
	input  logic [spy_pkg::SPY_ADDR_W-1:0] spy_addr,
	input  logic spy_rd,
	input  logic spy_wr,
	input  logic [spy_pkg::SPY_WORD_W-1:0] spy_wdata,
	output logic [spy_pkg::SPY_WORD_W-1:0] spy_rdata,
	output logic spy_rvalid,
	// processor state
	input  logic [48:0] ir,
	input  logic [31:0] ob,
	input  logic [31:0] md,
	input  logic [31:0] vma,
	input  logic [31:0] a,
	input  logic [31:0] m,
	input  logic [spy_pkg::PC_W-1:0] pc,
	input  logic [4:0] disk_state,
	input  logic [11:0] bd_state,
	input  logic state_write, waiting, boot, err, stat_halt,
	input  logic wmap, destspc, iwrited, imod, pdlwrite, spush,
	input  logic nop, vmaok, jcond, pcs1, pcs0,
	output logic cpu_run,
	output logic cpu_step,
	output logic promdisable
);

	logic sel_irh, sel_irm, sel_irl;
	logic sel_obh, sel_obl, sel_obh_now, sel_obl_now;
	logic sel_disk, sel_bd;
	logic sel_ah, sel_al, sel_mh, sel_ml;
	logic sel_mdh, sel_mdl, sel_vmah, sel_vmal;
	logic sel_flag2, sel_opc, sel_flag1, sel_pc, sel_scratch;
	logic dbread, opc_adv, scratch_wr, mode_wr;
	logic [spy_pkg::SPY_WORD_W-1:0] wdata_q;
	logic [spy_pkg::SPY_WORD_W-1:0] scratch;
	logic [spy_pkg::PC_W-1:0] opc;
	logic srun, ssdone, stathalt;

	spy_decode decode0 (
		.clk, .reset, .spy_addr, .spy_rd, .spy_wr, .spy_wdata,
		.sel_irh, .sel_irm, .sel_irl,
		.sel_obh, .sel_obl, .sel_obh_now, .sel_obl_now,
		.sel_disk, .sel_bd,
		.sel_ah, .sel_al, .sel_mh, .sel_ml,
		.sel_mdh, .sel_mdl, .sel_vmah, .sel_vmal,
		.sel_flag2, .sel_opc, .sel_flag1, .sel_pc, .sel_scratch,
		.dbread, .opc_adv, .scratch_wr, .mode_wr, .wdata_q
	);

	spy_control control0 (
		.clk, .reset, .scratch_wr, .mode_wr, .wdata_q, .state_write, .stat_halt,
		.scratch, .srun, .ssdone, .stathalt, .promdisable, .cpu_run, .cpu_step
	);

	opc_history history0 (
		.clk, .reset, .state_write, .pc, .opc_adv, .opc
	);

	spy_readout readout0 (
		.clk, .reset, .dbread, .state_write,
		.sel_irh, .sel_irm, .sel_irl,
		.sel_obh, .sel_obl, .sel_obh_now, .sel_obl_now,
		.sel_disk, .sel_bd,
		.sel_ah, .sel_al, .sel_mh, .sel_ml,
		.sel_mdh, .sel_mdl, .sel_vmah, .sel_vmal,
		.sel_flag2, .sel_opc, .sel_flag1, .sel_pc, .sel_scratch,
		.ir, .ob, .md, .vma, .a, .m, .pc, .opc, .scratch,
		.disk_state, .bd_state,
		.wmap, .destspc, .iwrited, .imod, .pdlwrite, .spush,
		.nop, .vmaok, .jcond, .pcs1, .pcs0,
		.waiting, .boot, .promdisable, .stathalt, .err, .ssdone, .srun,
		.spy_rdata
	);

	assign spy_rvalid = dbread; // read data lands one cycle after the strobe

endmodule

// File: verif/spy_port_asserts.sv
`timescale 1ns/1ps

module spy_port_asserts (
	input logic clk,
	input logic reset,
	input logic [spy_pkg::SPY_ADDR_W-1:0] spy_addr,
	input logic spy_rd,
	input logic spy_wr,
	input logic [spy_pkg::SPY_WORD_W-1:0] spy_wdata,
	input logic [spy_pkg::SPY_WORD_W-1:0] spy_rdata,
	input logic spy_rvalid,
	input logic [48:0] ir,
	input logic [31:0] ob, md, vma, a, m,
	input logic [spy_pkg::PC_W-1:0] pc,
	input logic [4:0] disk_state,
	input logic [11:0] bd_state,
	input logic state_write, waiting, boot, err, stat_halt,
	input logic wmap, destspc, iwrited, imod, pdlwrite, spush,
	input logic nop, vmaok, jcond, pcs1, pcs0,
	input logic cpu_run, cpu_step, promdisable
);

	logic [spy_pkg::SPY_ADDR_W-1:0] addr_q;
	logic [spy_pkg::SPY_WORD_W-1:0] wd_q, scratch_m, exp_word;
	logic mode_q, scr_q, opc_q;
	logic run_m, pd_m, halt_m, step_m, pend_m, done_m;
	logic [31:0] ob_m;
	logic [spy_pkg::PC_W-1:0] hist [spy_pkg::OPC_DEPTH]; // newest at index 0
	logic [spy_pkg::OPC_PTR_W-1:0] age;

	// reference model of the host-visible registers
	always_ff @(posedge clk) begin
		addr_q <= spy_addr;
		wd_q <= spy_wdata;
		if (state_write) begin
			hist[0] <= pc;
			for (int i = 1; i < spy_pkg::OPC_DEPTH; i++)
				hist[i] <= hist[i-1];
		end
		if (reset) begin
			{run_m, pd_m, halt_m, pend_m, done_m, step_m, mode_q, scr_q, opc_q} <= '0;
			scratch_m <= '0;
			ob_m <= '0;
			age <= '0;
		end else begin
			mode_q <= spy_wr && spy_addr == spy_pkg::SPY_A_MODE;
			scr_q <= spy_wr && spy_addr == spy_pkg::SPY_A_SCRATCH;
			opc_q <= spy_rd && spy_addr == spy_pkg::SPY_A_OPC;
			step_m <= mode_q && wd_q[spy_pkg::MODE_STEP];
			if (scr_q)
				scratch_m <= wd_q;
			if (state_write)
				ob_m <= ob;
			if (mode_q) begin
				run_m <= wd_q[spy_pkg::MODE_RUN];
				pd_m <= wd_q[spy_pkg::MODE_PROMDIS];
				halt_m <= 1'b0;
			end else if (stat_halt && run_m) begin
				halt_m <= 1'b1;
				run_m <= 1'b0;
			end
			if (mode_q)
				{pend_m, done_m} <= 2'b00;
			else if (step_m)
				pend_m <= 1'b1;
			else if (pend_m && state_write)
				{pend_m, done_m} <= 2'b01; // first state write after the step
			if (state_write)
				age <= '0;
			else if (opc_q)
				age <= age + 1'b1;
		end
	end

	always_comb begin
		case (addr_q)
			spy_pkg::SPY_A_IRH: exp_word = ir[47:32];
			spy_pkg::SPY_A_IRM: exp_word = ir[31:16];
			spy_pkg::SPY_A_IRL: exp_word = ir[15:0];
			spy_pkg::SPY_A_OBH: exp_word = ob_m[31:16];
			spy_pkg::SPY_A_OBL: exp_word = ob_m[15:0];
			spy_pkg::SPY_A_OBH_NOW: exp_word = ob[31:16];
			spy_pkg::SPY_A_OBL_NOW: exp_word = ob[15:0];
			spy_pkg::SPY_A_DISK: exp_word = {11'b0, disk_state};
			spy_pkg::SPY_A_BD: exp_word = {4'b0, bd_state};
			spy_pkg::SPY_A_AH: exp_word = a[31:16];
			spy_pkg::SPY_A_AL: exp_word = a[15:0];
			spy_pkg::SPY_A_MH: exp_word = m[31:16];
			spy_pkg::SPY_A_ML: exp_word = m[15:0];
			spy_pkg::SPY_A_MDH: exp_word = md[31:16];
			spy_pkg::SPY_A_MDL: exp_word = md[15:0];
			spy_pkg::SPY_A_VMAH: exp_word = vma[31:16];
			spy_pkg::SPY_A_VMAL: exp_word = vma[15:0];
			spy_pkg::SPY_A_FLAG2: exp_word = {2'b00, wmap, destspc, iwrited, imod, pdlwrite,
				spush, 2'b00, ir[48], nop, vmaok, jcond, pcs1, pcs0};
			spy_pkg::SPY_A_OPC: exp_word = {2'b00, hist[age]};
			spy_pkg::SPY_A_FLAG1: exp_word = {waiting, 1'b0, boot, pd_m, halt_m, err,
				done_m, run_m, 8'h00};
			spy_pkg::SPY_A_PC: exp_word = {2'b00, pc};
			spy_pkg::SPY_A_SCRATCH: exp_word = scratch_m;
			default: exp_word = spy_pkg::SPY_IDLE;
		endcase
	end

	read_data: assert property (@(posedge clk) disable iff (reset)
		spy_rd |=> spy_rvalid && spy_rdata == exp_word)
	else begin
		$error("ERR spy_rdata addr %h exp %h got %h valid %h", $sampled(addr_q),
			$sampled(exp_word), $sampled(spy_rdata), $sampled(spy_rvalid));
		spy_port_tb.assert_fails++;
	end

	idle_data: assert property (@(posedge clk) disable iff (reset)
		!spy_rd |=> !spy_rvalid && spy_rdata == spy_pkg::SPY_IDLE)
	else begin
		$error("ERR spy_rdata exp %h got %h valid %h", spy_pkg::SPY_IDLE,
			$sampled(spy_rdata), $sampled(spy_rvalid));
		spy_port_tb.assert_fails++;
	end

	reset_state: assert property (@(posedge clk)
		reset |=> !cpu_run && !cpu_step && !promdisable && !spy_rvalid)
	else begin
		$error("ERR after reset cpu_run %h cpu_step %h promdisable %h spy_rvalid %h",
			$sampled(cpu_run), $sampled(cpu_step), $sampled(promdisable),
			$sampled(spy_rvalid));
		spy_port_tb.assert_fails++;
	end

	run_bits: assert property (@(posedge clk) disable iff (reset)
		cpu_run == run_m && promdisable == pd_m)
	else begin
		$error("ERR cpu_run exp %h got %h promdisable exp %h got %h", $sampled(run_m),
			$sampled(cpu_run), $sampled(pd_m), $sampled(promdisable));
		spy_port_tb.assert_fails++;
	end

	step_pulse: assert property (@(posedge clk) disable iff (reset) cpu_step == step_m)
	else begin
		$error("ERR cpu_step exp %h got %h", $sampled(step_m), $sampled(cpu_step));
		spy_port_tb.assert_fails++;
	end

endmodule

// File: verif/spy_port_tb.sv
`timescale 1ns/1ps

module spy_port_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int N_SWEEP = 32;
	localparam int N_RANDOM = 160;
	localparam int N_TRANS = N_SWEEP + N_RANDOM + 70; // plus the directed accesses and state writes
	localparam int WATCHDOG_NS = (N_TRANS * 4 + RESET_CYCLES) * CLK_PERIOD;

	logic clk, reset;
	logic [spy_pkg::SPY_ADDR_W-1:0] spy_addr;
	logic spy_rd, spy_wr, spy_rvalid;
	logic [spy_pkg::SPY_WORD_W-1:0] spy_wdata, spy_rdata;
	logic [48:0] ir;
	logic [31:0] ob, md, vma, a, m;
	logic [spy_pkg::PC_W-1:0] pc;
	logic [4:0] disk_state;
	logic [11:0] bd_state;
	logic state_write, waiting, boot, err, stat_halt;
	logic wmap, destspc, iwrited, imod, pdlwrite, spush;
	logic nop, vmaok, jcond, pcs1, pcs0;
	logic cpu_run, cpu_step, promdisable;
	logic cpu_rand; // random pc, state_write and stat_halt when set
	int assert_fails = 0;
	int n_reads = 0;
	int n_writes = 0;

	spy_port dut0 (.*);

	bind spy_port spy_port_asserts asserts0 (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// processor state changes every cycle
	always @(negedge clk) begin
		ir = 49'({$urandom(), $urandom()});
		ob = $urandom();
		md = $urandom();
		vma = $urandom();
		a = $urandom();
		m = $urandom();
		disk_state = 5'($urandom());
		bd_state = 12'($urandom());
		{waiting, boot, err, wmap, destspc, iwrited, imod} = 7'($urandom());
		{pdlwrite, spush, nop, vmaok, jcond, pcs1, pcs0} = 7'($urandom());
		if (cpu_rand) begin
			pc = 14'($urandom());
			state_write = 1'($urandom());
			stat_halt = 1'($urandom()); // not running yet, so no halt
		end
	end

	task automatic read_word(input logic [spy_pkg::SPY_ADDR_W-1:0] addr);
		@(negedge clk);
		spy_addr = addr;
		spy_rd = 1'b1;
		@(negedge clk);
		spy_rd = 1'b0; // data is on spy_rdata for this cycle
		n_reads++;
	endtask

	task automatic write_reg(input logic [spy_pkg::SPY_ADDR_W-1:0] addr,
		input logic [spy_pkg::SPY_WORD_W-1:0] data);
		@(negedge clk);
		spy_addr = addr;
		spy_wdata = data;
		spy_wr = 1'b1;
		@(negedge clk);
		spy_wr = 1'b0;
		n_writes++;
	endtask

	task automatic pulse_state_write(input logic [spy_pkg::PC_W-1:0] pc_val);
		@(negedge clk);
		pc = pc_val;
		state_write = 1'b1;
		@(negedge clk);
		state_write = 1'b0;
	endtask

	initial begin
		logic [spy_pkg::SPY_ADDR_W-1:0] addr;

		void'($urandom(37));
		reset = 1'b1;
		cpu_rand = 1'b0;
		{spy_rd, spy_wr, spy_addr, spy_wdata} = '0;
		{ir, ob, md, vma, a, m, pc, disk_state, bd_state} = '0;
		{state_write, waiting, boot, err, stat_halt} = '0;
		{wmap, destspc, iwrited, imod, pdlwrite, spush} = '0;
		{nop, vmaok, jcond, pcs1, pcs0} = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		// every address but OPC once, unused ones included, then random ones
		@(posedge clk);
		cpu_rand = 1'b1;
		for (int i = 0; i < N_SWEEP; i++)
			if (5'(i) != spy_pkg::SPY_A_OPC)
				read_word(5'(i));
		for (int i = 0; i < N_RANDOM; i++) begin
			addr = 5'($urandom());
			if (addr == spy_pkg::SPY_A_OPC)
				addr = spy_pkg::SPY_A_PC;
			read_word(addr);
		end
		@(posedge clk);
		cpu_rand = 1'b0;
		@(negedge clk);
		state_write = 1'b0;
		stat_halt = 1'b0;

		pulse_state_write(14'h0);
		repeat (3) @(negedge clk); // ob moves on after the capture
		read_word(spy_pkg::SPY_A_OBH);
		read_word(spy_pkg::SPY_A_OBL);

		for (int i = 0; i < 8; i++) begin
			write_reg(spy_pkg::SPY_A_SCRATCH, 16'($urandom()));
			read_word(spy_pkg::SPY_A_SCRATCH);
			write_reg(spy_pkg::SPY_A_MODE, 16'($urandom()));
			read_word(spy_pkg::SPY_A_FLAG1);
		end

		write_reg(spy_pkg::SPY_A_MODE, 16'(1 << spy_pkg::MODE_STEP));
		do
			@(negedge clk);
		while (!cpu_step);
		pulse_state_write(14'h1);
		read_word(spy_pkg::SPY_A_FLAG1);
		write_reg(spy_pkg::SPY_A_MODE, 16'h0000);
		read_word(spy_pkg::SPY_A_FLAG1);

		// halt while running
		write_reg(spy_pkg::SPY_A_MODE, 16'(1 << spy_pkg::MODE_RUN));
		do
			@(negedge clk);
		while (!cpu_run);
		stat_halt = 1'b1;
		@(negedge clk);
		stat_halt = 1'b0;
		while (cpu_run)
			@(negedge clk);
		read_word(spy_pkg::SPY_A_FLAG1);

		for (int i = 0; i < spy_pkg::OPC_DEPTH; i++) begin
			@(negedge clk);
			pc = 14'(12'h123 + i * 37);
			state_write = 1'b1;
		end
		@(negedge clk);
		state_write = 1'b0;
		for (int i = 0; i < spy_pkg::OPC_DEPTH + 2; i++)
			read_word(spy_pkg::SPY_A_OPC); // walks back and wraps

		repeat (3) @(negedge clk);
		$display("reads %0d, writes %0d, assertion failures %0d",
			n_reads, n_writes, assert_fails);
		if (assert_fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the DUT never answered", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: flist.f
verilog/spy_pkg.sv
verilog/spy_decode.sv
verilog/spy_control.sv
verilog/opc_history.sv
verilog/spy_readout.sv
verilog/spy_port.sv
verif/spy_port_asserts.sv
verif/spy_port_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the spy port testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module spy_port_tb -o spy_port_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/spy_port_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1
